//--- hdl/cache_bank_config.svh
`ifndef CACHE_BANK_CONFIG_SVH
`define CACHE_BANK_CONFIG_SVH

// Line and array geometry
`define CB_LINE_WORDS 4
`define CB_SETS       16

// Queue depths
`define CB_REQQ_DEPTH  4
`define CB_FILLQ_DEPTH 4
`define CB_RSPQ_DEPTH  4
`define CB_WBQ_DEPTH   4

// Missed requests waiting for their fill
`define CB_MRV_SIZE 4

`endif

//--- hdl/cache_addr_pkg.sv
`default_nettype none

`include "cache_bank_config.svh"

package cache_addr_pkg;

	localparam int SET_W = $clog2(`CB_SETS);
	localparam int TAG_W = 32 - SET_W - 4;

	typedef logic [31:0] word_t;
	typedef word_t [`CB_LINE_WORDS-1:0] line_t;
	typedef logic [SET_W-1:0] set_t;
	typedef logic [1:0] offset_t;
	typedef logic [TAG_W-1:0] tag_t;
	// Word address of the first word in a line
	typedef logic [29:0] line_addr_t;

	function automatic tag_t addr_tag(word_t addr);
		return addr[31-:TAG_W];
	endfunction

	function automatic set_t addr_set(word_t addr);
		return addr[4+:SET_W];
	endfunction

	function automatic offset_t addr_offset(word_t addr);
		return addr[3:2];
	endfunction

	function automatic line_addr_t line_of(word_t addr);
		return {addr[31:4], 2'b00};
	endfunction

endpackage

`default_nettype wire

//--- hdl/cache_req_pkg.sv
`default_nettype none

package cache_req_pkg;

	typedef logic [3:0] req_id_t;

	typedef struct packed {
		logic                  is_write;
		cache_addr_pkg::word_t addr;
		cache_addr_pkg::word_t wdata;
		req_id_t               id;
	} core_req_t;

	typedef struct packed {
		req_id_t               id;
		cache_addr_pkg::word_t data;
	} core_rsp_t;

	typedef struct packed {
		cache_addr_pkg::line_addr_t addr;
		cache_addr_pkg::line_t      data;
	} fill_rsp_t;

	typedef struct packed {
		cache_addr_pkg::line_addr_t addr;
		cache_addr_pkg::line_t      data;
	} dram_wb_t;

	// One pipeline slot, st0 through st2
	typedef struct packed {
		logic                  valid;
		logic                  is_fill;
		logic                  is_write;
		cache_addr_pkg::word_t addr;
		cache_addr_pkg::word_t wdata;
		req_id_t               id;
		cache_addr_pkg::line_t fill_line;
	} st_entry_t;

endpackage

`default_nettype wire

//--- hdl/bank_queue.sv
`timescale 1ns/100ps
`default_nettype none

module bank_queue #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 4
) (
	input  wire           clk,
	input  wire           reset,
	input  wire           in_valid,
	output logic          in_ready,
	input  wire payload_t in_data,
	output logic          out_valid,
	input  wire           out_ready,
	output payload_t      out_data
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	payload_t      mem [DEPTH];
	logic [AW-1:0] rd_ptr;
	logic [AW-1:0] wr_ptr;
	logic [CW-1:0] count;
	logic [CW-1:0] count_next;
	logic          push;
	logic          pop;

	function automatic logic [AW-1:0] bump(logic [AW-1:0] ptr);
		return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign push       = in_valid && in_ready;
	assign pop        = out_valid && out_ready;
	assign out_valid  = (count != '0);
	assign out_data   = mem[rd_ptr];
	assign count_next = count + CW'(push) - CW'(pop);

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr   <= '0;
			wr_ptr   <= '0;
			count    <= '0;
			in_ready <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= bump(wr_ptr);
			if (pop)
				rd_ptr <= bump(rd_ptr);
			count    <= count_next;
			in_ready <= (count_next < CW'(DEPTH));
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in_data;
	end

	count_in_range: assert property (@(posedge clk) disable iff (reset) count <= CW'(DEPTH));

endmodule

`default_nettype wire

//--- hdl/bank_miss_reservation.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_bank_config.svh"

module bank_miss_reservation (
	input  wire                             clk,
	input  wire                             reset,
	input  wire                             add_valid,
	input  wire cache_req_pkg::st_entry_t   add_entry,
	output logic                            add_ready,
	input  wire                             fill_done_valid,
	input  wire cache_addr_pkg::line_addr_t fill_done_addr,
	input  wire                             pop,
	output logic                            head_ready,
	output cache_req_pkg::st_entry_t        head_entry
);

	localparam int N  = `CB_MRV_SIZE;
	localparam int IW = (N > 1) ? $clog2(N) : 1;

	// Kept compacted, oldest at index 0
	cache_req_pkg::st_entry_t ents      [N];
	cache_req_pkg::st_entry_t ents_next [N];
	logic [N-1:0]             occ;
	logic [N-1:0]             occ_next;
	logic [N-1:0]             rdy;
	logic [N-1:0]             rdy_next;
	logic [IW-1:0]            sel;

	always_comb begin
		head_ready = 1'b0;
		sel        = '0;
		for (int i = N - 1; i >= 0; i--) begin
			if (occ[i] && rdy[i]) begin
				head_ready = 1'b1;
				sel        = IW'(i);
			end
		end
	end

	assign head_entry = ents[sel];
	assign add_ready  = !occ[N-1];

	always_comb begin
		logic placed;
		placed    = 1'b0;
		ents_next = ents;
		occ_next  = occ;
		rdy_next  = rdy;
		if (fill_done_valid) begin
			for (int i = 0; i < N; i++) begin
				if (occ[i] && cache_addr_pkg::line_of(ents[i].addr) == fill_done_addr)
					rdy_next[i] = 1'b1;
			end
		end
		// Close the gap behind the popped entry
		if (pop) begin
			for (int i = 0; i < N - 1; i++) begin
				if (i >= sel) begin
					ents_next[i] = ents_next[i+1];
					occ_next[i]  = occ_next[i+1];
					rdy_next[i]  = rdy_next[i+1];
				end
			end
			occ_next[N-1] = 1'b0;
			rdy_next[N-1] = 1'b0;
		end
		if (add_valid && add_ready) begin
			for (int i = 0; i < N; i++) begin
				if (!occ_next[i] && !placed) begin
					ents_next[i] = add_entry;
					occ_next[i]  = 1'b1;
					rdy_next[i]  = 1'b0;
					placed       = 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			occ <= '0;
			rdy <= '0;
		end else begin
			occ <= occ_next;
			rdy <= rdy_next;
		end
	end

	always_ff @(posedge clk) begin
		ents <= ents_next;
	end

	pop_needs_ready: assert property (@(posedge clk) disable iff (reset) pop |-> head_ready);

endmodule

`default_nettype wire

//--- hdl/bank_tag_store.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_bank_config.svh"

module bank_tag_store (
	input  wire                           clk,
	input  wire                           reset,
	input  wire                           stall,
	input  wire cache_req_pkg::st_entry_t rd_entry,
	output logic                          hit,
	output logic                          victim_dirty,
	output cache_addr_pkg::tag_t          victim_tag
);

	cache_addr_pkg::tag_t tags [`CB_SETS];
	logic [`CB_SETS-1:0]  valid_bits;
	logic [`CB_SETS-1:0]  dirty_bits;
	cache_addr_pkg::set_t set_idx;
	cache_addr_pkg::tag_t tag;
	logic                 update;

	assign set_idx      = cache_addr_pkg::addr_set(rd_entry.addr);
	assign tag          = cache_addr_pkg::addr_tag(rd_entry.addr);
	assign victim_tag   = tags[set_idx];
	assign victim_dirty = valid_bits[set_idx] && dirty_bits[set_idx];
	assign hit          = rd_entry.valid && valid_bits[set_idx] && (tags[set_idx] == tag);
	assign update       = rd_entry.valid && !stall;

	always_ff @(posedge clk) begin
		if (update && rd_entry.is_fill && !hit)
			tags[set_idx] <= tag;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else if (update) begin
			if (rd_entry.is_fill) begin
				// A resident line keeps its newer contents
				if (!hit) begin
					valid_bits[set_idx] <= 1'b1;
					dirty_bits[set_idx] <= 1'b0;
				end
			end else if (hit) begin
				if (rd_entry.is_write)
					dirty_bits[set_idx] <= 1'b1;
			end else if (victim_dirty) begin
				// Victim data leaves with this miss
				dirty_bits[set_idx] <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/bank_data_store.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_bank_config.svh"

module bank_data_store (
	input  wire                           clk,
	input  wire                           stall,
	input  wire cache_req_pkg::st_entry_t rd_entry,
	input  wire                           hit,
	output cache_addr_pkg::line_t         read_line,
	output cache_addr_pkg::word_t         read_word
);

	cache_addr_pkg::line_t   lines [`CB_SETS];
	cache_addr_pkg::set_t    set_idx;
	cache_addr_pkg::offset_t offset;

	assign set_idx   = cache_addr_pkg::addr_set(rd_entry.addr);
	assign offset    = cache_addr_pkg::addr_offset(rd_entry.addr);
	assign read_line = lines[set_idx];
	assign read_word = lines[set_idx][offset];

	always_ff @(posedge clk) begin
		if (rd_entry.valid && !stall) begin
			if (rd_entry.is_fill) begin
				if (!hit)
					lines[set_idx] <= rd_entry.fill_line;
			end else if (rd_entry.is_write && hit) begin
				lines[set_idx][offset] <= rd_entry.wdata;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/bank_response_router.sv
`timescale 1ns/100ps
`default_nettype none

module bank_response_router (
	input  wire cache_req_pkg::st_entry_t st2_entry,
	input  wire                           hit,
	input  wire                           victim_dirty,
	input  wire cache_addr_pkg::tag_t     victim_tag,
	input  wire cache_addr_pkg::line_t    read_line,
	input  wire cache_addr_pkg::word_t    read_word,
	input  wire                           rsp_ready,
	input  wire                           wb_ready,
	input  wire                           mrv_ready,
	input  wire                           fill_req_ready,
	output logic                          rsp_push,
	output cache_req_pkg::core_rsp_t      rsp_data,
	output logic                          wb_push,
	output cache_req_pkg::dram_wb_t       wb_data,
	output logic                          mrv_add,
	output logic                          fill_req_valid,
	output cache_addr_pkg::line_addr_t    fill_req_addr,
	output logic                          fill_done_valid,
	output logic                          stall
);

	logic need_rsp;
	logic need_miss;
	logic need_wb;
	logic rsp_ok;
	logic wb_ok;
	logic mrv_ok;
	logic fill_ok;

	assign need_rsp  = st2_entry.valid && !st2_entry.is_fill && hit;
	assign need_miss = st2_entry.valid && !st2_entry.is_fill && !hit;
	// Also covers a fill that replaces a line written again since its miss
	assign need_wb   = st2_entry.valid && !hit && victim_dirty;

	assign rsp_ok  = !need_rsp || rsp_ready;
	assign wb_ok   = !need_wb || wb_ready;
	assign mrv_ok  = !need_miss || mrv_ready;
	assign fill_ok = !need_miss || fill_req_ready;
	assign stall   = !(rsp_ok && wb_ok && mrv_ok && fill_ok);

	assign rsp_push        = need_rsp && !stall;
	assign wb_push         = need_wb && !stall;
	assign mrv_add         = need_miss && !stall;
	assign fill_req_valid  = need_miss && wb_ok && mrv_ok;
	assign fill_req_addr   = cache_addr_pkg::line_of(st2_entry.addr);
	assign fill_done_valid = st2_entry.valid && st2_entry.is_fill && !stall;

	assign rsp_data = '{
		id:   st2_entry.id,
		data: st2_entry.is_write ? st2_entry.wdata : read_word
	};
	assign wb_data = '{
		addr: {victim_tag, cache_addr_pkg::addr_set(st2_entry.addr), 2'b00},
		data: read_line
	};

endmodule

`default_nettype wire

//--- hdl/cache_bank.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_bank_config.svh"

module cache_bank (
	input  wire                             clk,
	input  wire                             reset,
	input  wire                             core_req_valid,
	output logic                            core_req_ready,
	input  wire cache_req_pkg::core_req_t   core_req,
	output logic                            core_rsp_valid,
	input  wire                             core_rsp_ready,
	output cache_req_pkg::core_rsp_t        core_rsp,
	output logic                            fill_req_valid,
	input  wire                             fill_req_ready,
	output cache_addr_pkg::line_addr_t      fill_req_addr,
	input  wire                             fill_rsp_valid,
	output logic                            fill_rsp_ready,
	input  wire cache_req_pkg::fill_rsp_t   fill_rsp,
	output logic                            dram_wb_valid,
	input  wire                             dram_wb_ready,
	output cache_req_pkg::dram_wb_t         dram_wb
);

	localparam int MRV_N = `CB_MRV_SIZE;
	localparam int MW    = $clog2(MRV_N + 1);

	cache_req_pkg::core_req_t reqq_head;
	cache_req_pkg::fill_rsp_t fillq_head;
	cache_req_pkg::st_entry_t mrv_head;
	cache_req_pkg::st_entry_t fill_cand;
	cache_req_pkg::st_entry_t req_cand;
	cache_req_pkg::st_entry_t st0;
	cache_req_pkg::st_entry_t st1;
	cache_req_pkg::st_entry_t st2;
	cache_req_pkg::core_rsp_t rsp_data;
	cache_req_pkg::dram_wb_t  wb_data;
	cache_addr_pkg::tag_t     vtag_st1;
	cache_addr_pkg::tag_t     vtag_st2;
	cache_addr_pkg::line_t    line_st1;
	cache_addr_pkg::line_t    line_st2;
	cache_addr_pkg::word_t    word_st1;
	cache_addr_pkg::word_t    word_st2;
	logic                     hit_st1;
	logic                     hit_st2;
	logic                     vdirty_st1;
	logic                     vdirty_st2;
	logic                     reqq_valid;
	logic                     fillq_valid;
	logic                     mrv_head_ready;
	logic                     fill_go;
	logic                     mrv_go;
	logic                     req_go;
	logic                     stall;
	logic                     rsp_push;
	logic                     rsp_ready;
	logic                     wb_push;
	logic                     wb_ready;
	logic                     mrv_add;
	logic                     mrv_ready;
	logic                     fill_done;
	logic                     route_fill_valid;
	logic [MW-1:0]            mrv_used;
	logic [1:0]               inflight;
	logic                     mrv_room;

	// Line-writing entry in st1 blocks st0 candidates on the same line
	function automatic logic line_busy(cache_addr_pkg::word_t addr,
	                                   cache_req_pkg::st_entry_t e);
		return e.valid && (e.is_fill || e.is_write) &&
		       (cache_addr_pkg::line_of(addr) == cache_addr_pkg::line_of(e.addr));
	endfunction

	bank_queue #(.payload_t(cache_req_pkg::core_req_t), .DEPTH(`CB_REQQ_DEPTH)) req_queue (
		.clk      (clk),
		.reset    (reset),
		.in_valid (core_req_valid),
		.in_ready (core_req_ready),
		.in_data  (core_req),
		.out_valid(reqq_valid),
		.out_ready(req_go),
		.out_data (reqq_head)
	);

	bank_queue #(.payload_t(cache_req_pkg::fill_rsp_t), .DEPTH(`CB_FILLQ_DEPTH)) fill_queue (
		.clk      (clk),
		.reset    (reset),
		.in_valid (fill_rsp_valid),
		.in_ready (fill_rsp_ready),
		.in_data  (fill_rsp),
		.out_valid(fillq_valid),
		.out_ready(fill_go),
		.out_data (fillq_head)
	);

	bank_queue #(.payload_t(cache_req_pkg::core_rsp_t), .DEPTH(`CB_RSPQ_DEPTH)) rsp_queue (
		.clk      (clk),
		.reset    (reset),
		.in_valid (rsp_push),
		.in_ready (rsp_ready),
		.in_data  (rsp_data),
		.out_valid(core_rsp_valid),
		.out_ready(core_rsp_ready),
		.out_data (core_rsp)
	);

	bank_queue #(.payload_t(cache_req_pkg::dram_wb_t), .DEPTH(`CB_WBQ_DEPTH)) wb_queue (
		.clk      (clk),
		.reset    (reset),
		.in_valid (wb_push),
		.in_ready (wb_ready),
		.in_data  (wb_data),
		.out_valid(dram_wb_valid),
		.out_ready(dram_wb_ready),
		.out_data (dram_wb)
	);

	bank_miss_reservation mrv (
		.clk            (clk),
		.reset          (reset),
		.add_valid      (mrv_add),
		.add_entry      (st2),
		.add_ready      (mrv_ready),
		.fill_done_valid(fill_done),
		.fill_done_addr (cache_addr_pkg::line_of(st2.addr)),
		.pop            (mrv_go),
		.head_ready     (mrv_head_ready),
		.head_entry     (mrv_head)
	);

	assign fill_cand = '{
		valid:     1'b1,
		is_fill:   1'b1,
		is_write:  1'b0,
		addr:      {fillq_head.addr, 2'b00},
		wdata:     '0,
		id:        '0,
		fill_line: fillq_head.data
	};
	assign req_cand = '{
		valid:     1'b1,
		is_fill:   1'b0,
		is_write:  reqq_head.is_write,
		addr:      reqq_head.addr,
		wdata:     reqq_head.wdata,
		id:        reqq_head.id,
		fill_line: '0
	};

	// New requests enter only if every possible miss still finds a reservation slot
	assign inflight = 2'(st1.valid && !st1.is_fill) + 2'(st2.valid && !st2.is_fill);
	assign mrv_room = (int'(mrv_used) + int'(inflight)) < MRV_N;

	assign fill_go = fillq_valid && !stall && !line_busy(fill_cand.addr, st1);
	assign mrv_go  = mrv_head_ready && !stall && !fill_go && !line_busy(mrv_head.addr, st1);
	assign req_go  = reqq_valid && !stall && !fill_go && !mrv_go && mrv_room &&
	                 !line_busy(reqq_head.addr, st1);

	always_comb begin
		st0 = '0;
		if (fill_go)
			st0 = fill_cand;
		else if (mrv_go)
			st0 = mrv_head;
		else if (req_go)
			st0 = req_cand;
	end

	bank_tag_store tag_store (
		.clk         (clk),
		.reset       (reset),
		.stall       (stall),
		.rd_entry    (st1),
		.hit         (hit_st1),
		.victim_dirty(vdirty_st1),
		.victim_tag  (vtag_st1)
	);

	bank_data_store data_store (
		.clk      (clk),
		.stall    (stall),
		.rd_entry (st1),
		.hit      (hit_st1),
		.read_line(line_st1),
		.read_word(word_st1)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			st1.valid <= 1'b0;
			st2.valid <= 1'b0;
		end else if (!stall) begin
			st1        <= st0;
			st2        <= st1;
			hit_st2    <= hit_st1;
			vdirty_st2 <= vdirty_st1;
			vtag_st2   <= vtag_st1;
			line_st2   <= line_st1;
			word_st2   <= word_st1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			mrv_used <= '0;
		else
			mrv_used <= mrv_used + MW'(mrv_add) - MW'(mrv_go);
	end

	bank_response_router router (
		.st2_entry      (st2),
		.hit            (hit_st2),
		.victim_dirty   (vdirty_st2),
		.victim_tag     (vtag_st2),
		.read_line      (line_st2),
		.read_word      (word_st2),
		.rsp_ready      (rsp_ready),
		.wb_ready       (wb_ready),
		.mrv_ready      (mrv_ready),
		.fill_req_ready (fill_req_ready && !dram_wb_valid),
		.rsp_push       (rsp_push),
		.rsp_data       (rsp_data),
		.wb_push        (wb_push),
		.wb_data        (wb_data),
		.mrv_add        (mrv_add),
		.fill_req_valid (route_fill_valid),
		.fill_req_addr  (fill_req_addr),
		.fill_done_valid(fill_done),
		.stall          (stall)
	);

	// DRAM sees every queued writeback before the next fill request
	assign fill_req_valid = route_fill_valid && !dram_wb_valid;

	// A waiting fill request stays up with the same line until DRAM takes it
	fill_req_held: assert property (@(posedge clk) disable iff (reset)
		fill_req_valid && !fill_req_ready |=> fill_req_valid && $stable(fill_req_addr));

endmodule

`default_nettype wire

//--- sim/bank_checker.sv
`timescale 1ns/100ps
`default_nettype none

module bank_checker (
	input  wire                             clk,
	input  wire                             reset,
	input  wire                             core_req_valid,
	input  wire                             core_req_ready,
	input  wire cache_req_pkg::core_req_t   core_req,
	input  wire cache_addr_pkg::word_t      req_expect,
	input  wire                             core_rsp_valid,
	input  wire                             core_rsp_ready,
	input  wire cache_req_pkg::core_rsp_t   core_rsp,
	input  wire                             fill_req_valid,
	input  wire                             fill_req_ready,
	input  wire cache_addr_pkg::line_addr_t fill_req_addr,
	input  wire                             dram_wb_valid,
	input  wire                             dram_wb_ready,
	input  wire cache_req_pkg::dram_wb_t    dram_wb,
	output int                              value_errors,
	output int                              other_errors,
	output int                              wb_seen,
	output int                              outstanding
);

	cache_addr_pkg::word_t exp_data  [16];
	cache_addr_pkg::word_t exp_addr  [16];
	cache_addr_pkg::word_t exp_wdata [16];
	logic                  exp_write [16];
	logic [15:0]           pend;
	// Words written by completed writes, by byte address
	cache_addr_pkg::word_t shadow [cache_addr_pkg::word_t];

	assign outstanding = $countones(pend);

	always @(posedge clk) begin
		int                    id;
		logic                  found;
		cache_addr_pkg::word_t a;
		cache_addr_pkg::word_t want;
		if (reset) begin
			pend         = '0;
			value_errors = 0;
			other_errors = 0;
			wb_seen      = 0;
		end else begin
			if (core_rsp_valid && core_rsp_ready) begin
				id = core_rsp.id;
				if (!pend[id]) begin
					other_errors++;
					$display("Response at %0t carries id %0d, which has no open request", $time, id);
				end else begin
					if (core_rsp.data !== exp_data[id]) begin
						value_errors++;
						$display("ERR %0t: id %0d returned %h, expected %h",
						         $time, id, core_rsp.data, exp_data[id]);
					end
					if (exp_write[id])
						shadow[exp_addr[id]] = exp_wdata[id];
					pend[id] = 1'b0;
				end
			end
			if (core_req_valid && core_req_ready) begin
				id = core_req.id;
				if (pend[id]) begin
					other_errors++;
					$display("Request id %0d was reused at %0t while still open", id, $time);
				end
				pend[id]      = 1'b1;
				exp_data[id]  = req_expect;
				exp_addr[id]  = core_req.addr;
				exp_wdata[id] = core_req.wdata;
				exp_write[id] = core_req.is_write;
			end
			if (fill_req_valid && fill_req_ready) begin
				found = 1'b0;
				for (int i = 0; i < 16; i++) begin
					if (pend[i] && exp_addr[i][31:4] == fill_req_addr[29:2])
						found = 1'b1;
				end
				if (!found) begin
					value_errors++;
					$display("ERR %0t: fill request for line %h with no open miss",
					         $time, fill_req_addr);
				end
			end
			if (dram_wb_valid && dram_wb_ready) begin
				wb_seen++;
				for (int w = 0; w < 4; w++) begin
					a = {dram_wb.addr, 2'b00} + 32'(4 * w);
					// Unwritten words still carry the DRAM start pattern
					if (shadow.exists(a))
						want = shadow[a];
					else
						want = a ^ 32'hC0DE_0000;
					if (dram_wb.data[w] !== want) begin
						value_errors++;
						$display("ERR %0t: writeback word %h is %h, expected %h",
						         $time, a, dram_wb.data[w], want);
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- sim/cache_bank_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cache_bank_tb;

	logic                       clk;
	logic                       reset;
	logic                       core_req_valid;
	logic                       core_req_ready;
	cache_req_pkg::core_req_t   core_req;
	cache_addr_pkg::word_t      req_expect;
	logic                       core_rsp_valid;
	logic                       core_rsp_ready;
	cache_req_pkg::core_rsp_t   core_rsp;
	logic                       fill_req_valid;
	logic                       fill_req_ready;
	cache_addr_pkg::line_addr_t fill_req_addr;
	logic                       fill_rsp_valid;
	logic                       fill_rsp_ready;
	cache_req_pkg::fill_rsp_t   fill_rsp;
	logic                       dram_wb_valid;
	logic                       dram_wb_ready;
	cache_req_pkg::dram_wb_t    dram_wb;

	int value_errors;
	int other_errors;
	int wb_seen;
	int outstanding;
	int tb_errors;
	int cycles;
	int limit;

	// Stimulus table
	logic [1:0]            st_op   [$];
	cache_addr_pkg::word_t st_addr [$];
	cache_addr_pkg::word_t st_wd   [$];
	logic [3:0]            st_id   [$];
	cache_addr_pkg::word_t st_exp  [$];

	logic [15:0]           busy;
	logic [27:0]           busy_line [16];
	logic                  holding;
	logic                  hold_used;
	logic                  released;

	// DRAM model
	cache_addr_pkg::word_t      dram [cache_addr_pkg::word_t];
	cache_addr_pkg::line_addr_t fill_q      [$];
	int                         fill_time_q [$];
	logic                       fill_accept;
	logic [31:0]                lcg_state;
	int                         drop_left;

	cache_bank DUT (
		.clk           (clk),
		.reset         (reset),
		.core_req_valid(core_req_valid),
		.core_req_ready(core_req_ready),
		.core_req      (core_req),
		.core_rsp_valid(core_rsp_valid),
		.core_rsp_ready(core_rsp_ready),
		.core_rsp      (core_rsp),
		.fill_req_valid(fill_req_valid),
		.fill_req_ready(fill_req_ready),
		.fill_req_addr (fill_req_addr),
		.fill_rsp_valid(fill_rsp_valid),
		.fill_rsp_ready(fill_rsp_ready),
		.fill_rsp      (fill_rsp),
		.dram_wb_valid (dram_wb_valid),
		.dram_wb_ready (dram_wb_ready),
		.dram_wb       (dram_wb)
	);

	bank_checker chk (
		.clk           (clk),
		.reset         (reset),
		.core_req_valid(core_req_valid),
		.core_req_ready(core_req_ready),
		.core_req      (core_req),
		.req_expect    (req_expect),
		.core_rsp_valid(core_rsp_valid),
		.core_rsp_ready(core_rsp_ready),
		.core_rsp      (core_rsp),
		.fill_req_valid(fill_req_valid),
		.fill_req_ready(fill_req_ready),
		.fill_req_addr (fill_req_addr),
		.dram_wb_valid (dram_wb_valid),
		.dram_wb_ready (dram_wb_ready),
		.dram_wb       (dram_wb),
		.value_errors  (value_errors),
		.other_errors  (other_errors),
		.wb_seen       (wb_seen),
		.outstanding   (outstanding)
	);

	function automatic logic [31:0] lcg_next(logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic cache_addr_pkg::word_t dram_read(cache_addr_pkg::word_t a);
		if (dram.exists(a))
			return dram[a];
		return a ^ 32'hC0DE_0000;
	endfunction

	function automatic logic line_taken(cache_addr_pkg::word_t a);
		for (int i = 0; i < 16; i++) begin
			if (busy[i] && busy_line[i] == a[31:4])
				return 1'b1;
		end
		return 1'b0;
	endfunction

	initial clk = 1'b0;
	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("Run stopped by timeout after %0d cycles, %0d requests still open",
			         cycles, outstanding);
			$display("errors: %0d value, %0d other", value_errors,
			         other_errors + tb_errors + 1);
			$display(">>> FAIL");
			$finish;
		end
	end

	always @(posedge clk) begin
		if (core_rsp_valid && core_rsp_ready)
			busy[core_rsp.id] <= 1'b0;
		if (fill_req_valid && fill_req_ready) begin
			fill_q.push_back(fill_req_addr);
			fill_time_q.push_back(cycles);
		end
		if (dram_wb_valid && dram_wb_ready) begin
			for (int w = 0; w < 4; w++)
				dram[{dram_wb.addr, 2'b00} + 32'(4 * w)] = dram_wb.data[w];
		end
	end

	// Fill responses a few cycles after each request
	always @(negedge clk) begin
		if (fill_rsp_valid && fill_accept) begin
			fill_rsp_valid = 1'b0;
			fill_accept    = 1'b0;
		end else if (!fill_rsp_valid && fill_q.size() > 0 && cycles >= fill_time_q[0] + 3) begin
			fill_rsp.addr = fill_q.pop_front();
			void'(fill_time_q.pop_front());
			for (int w = 0; w < 4; w++)
				fill_rsp.data[w] = dram_read({fill_rsp.addr, 2'b00} + 32'(4 * w));
			fill_rsp_valid = 1'b1;
		end
		if (fill_rsp_valid)
			fill_accept = fill_rsp_ready;
	end

	// Random stretches of low ready toward DRAM
	always @(negedge clk) begin
		if (!reset) begin
			if (drop_left > 0) begin
				drop_left--;
				fill_req_ready = 1'b0;
				dram_wb_ready  = 1'b0;
			end else begin
				lcg_state = lcg_next(lcg_state);
				if (lcg_state[18:16] == 3'd0) begin
					drop_left      = 1 + int'(lcg_state[22:20]);
					fill_req_ready = 1'b0;
					dram_wb_ready  = 1'b0;
				end else begin
					fill_req_ready = 1'b1;
					dram_wb_ready  = 1'b1;
				end
			end
		end
	end

	always @(negedge clk) begin
		if (holding && core_req_valid && !core_req_ready) begin
			holding        = 1'b0;
			released       = 1'b1;
			core_rsp_ready = 1'b1;
		end
	end

	task automatic send(int k);
		while (busy[st_id[k]] || line_taken(st_addr[k]))
			@(negedge clk);
		core_req_valid = 1'b1;
		core_req = '{is_write: st_op[k][0], addr: st_addr[k], wdata: st_wd[k], id: st_id[k]};
		req_expect = st_exp[k];
		busy[st_id[k]]      = 1'b1;
		busy_line[st_id[k]] = st_addr[k][31:4];
		// Ready only changes on the rising edge
		while (!core_req_ready)
			@(negedge clk);
		@(negedge clk);
		core_req_valid = 1'b0;
	endtask

	task automatic read_stimulus(output int ok);
		int    fd;
		int    n;
		string text;
		logic [31:0] op;
		logic [31:0] a;
		logic [31:0] wd;
		logic [31:0] id;
		logic [31:0] ex;
		ok = 0;
		fd = $fopen("sim/bank_stimulus.txt", "r");
		if (fd == 0)
			return;
		while (!$feof(fd)) begin
			n = $fgets(text, fd);
			if (n > 1 && text.getc(0) != "#") begin
				n = $sscanf(text, "%h %h %h %h %h", op, a, wd, id, ex);
				if (n == 5) begin
					st_op.push_back(op[1:0]);
					st_addr.push_back(a);
					st_wd.push_back(wd);
					st_id.push_back(id[3:0]);
					st_exp.push_back(ex);
				end
			end
		end
		$fclose(fd);
		ok = 1;
	endtask

	initial begin
		int ok;
		reset          = 1'b1;
		core_req_valid = 1'b0;
		core_req       = '0;
		req_expect     = '0;
		core_rsp_ready = 1'b1;
		fill_req_ready = 1'b0;
		fill_rsp_valid = 1'b0;
		fill_rsp       = '0;
		dram_wb_ready  = 1'b0;
		fill_accept    = 1'b0;
		lcg_state      = 32'd7515;
		drop_left      = 0;
		busy           = '0;
		holding        = 1'b0;
		hold_used      = 1'b0;
		released       = 1'b0;
		tb_errors      = 0;
		cycles         = 0;
		limit          = 0;
		read_stimulus(ok);
		if (!ok || st_op.size() == 0) begin
			$display("Could not read any stimulus from sim/bank_stimulus.txt");
			$display(">>> FAIL");
			$finish;
		end else begin
			limit = 200 * st_op.size();
			repeat (5) @(posedge clk);
			@(negedge clk);
			reset = 1'b0;
			for (int k = 0; k < st_op.size(); k++) begin
				if (st_op[k] == 2'd2) begin
					@(negedge clk);
					core_rsp_ready = 1'b0;
					holding        = 1'b1;
					hold_used      = 1'b1;
				end else begin
					send(k);
				end
			end
			while (busy != '0 || holding)
				@(negedge clk);
			repeat (10) @(negedge clk);
			if (outstanding != 0) begin
				tb_errors++;
				$display("%0d responses never arrived", outstanding);
			end
			if (hold_used && !released) begin
				tb_errors++;
				$display("Request ready never dropped while responses were held");
			end
			if (wb_seen == 0) begin
				tb_errors++;
				$display("No dirty line was ever written back to DRAM");
			end
			$display("errors: %0d value, %0d other", value_errors, other_errors + tb_errors);
			if (value_errors + other_errors + tb_errors == 0)
				$display(">>> PASS");
			else
				$display(">>> FAIL");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+hdl
hdl/cache_addr_pkg.sv
hdl/cache_req_pkg.sv
hdl/bank_queue.sv
hdl/bank_miss_reservation.sv
hdl/bank_tag_store.sv
hdl/bank_data_store.sv
hdl/bank_response_router.sv
hdl/cache_bank.sv
sim/bank_checker.sv
sim/cache_bank_tb.sv

//--- sim/bank_stimulus.txt
# op addr wdata id expect (hex); op 0 read, 1 write, 2 hold core_rsp ready low
# DRAM word at byte address a starts as a ^ C0DE0000
0 00001010 00000000 0 C0DE1010
1 00001014 11112222 1 11112222
0 00001014 00000000 2 11112222
0 00002018 00000000 3 C0DE2018
0 00001014 00000000 4 11112222
2 00000000 00000000 0 00000000
0 00003000 00000000 5 C0DE3000
0 00003010 00000000 6 C0DE3010
0 00003020 00000000 7 C0DE3020
0 00003030 00000000 8 C0DE3030
0 00003040 00000000 9 C0DE3040
0 00003050 00000000 a C0DE3050
0 00003060 00000000 b C0DE3060
0 00003070 00000000 c C0DE3070
0 00003080 00000000 d C0DE3080
0 00003090 00000000 e C0DE3090
0 000030a0 00000000 f C0DE30A0
0 000030b0 00000000 0 C0DE30B0
0 000030c0 00000000 1 C0DE30C0
1 00005024 aaaa5555 2 AAAA5555
0 00006020 00000000 3 C0DE6020
0 00005024 00000000 4 AAAA5555
